// ==== list.f ====
eth_tc_pkg.sv
eth_tc_csr_decode.sv
eth_pkt_gen.sv
eth_pkt_mon.sv
eth_std_channel.sv
eth_tc_readback.sv
eth_traffic_controller_top.sv
eth_tc_asserts.sv
tb_eth_traffic_controller.sv

// ==== tb_eth_traffic_controller.sv ====
/*
 * testbench for the ethernet traffic controller
 * loops each transmit stream back to its receive stream with random
 * back-pressure and bit-flip injection, checks beats and registers
 */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_traffic_controller;

	localparam int NCH = 2;
	localparam int RUN_LENS [4] = '{8, 1, 17, 0};

	logic                                clk;
	logic                                rst_n;
	logic                                avl_mm_read;
	logic                                avl_mm_write;
	eth_tc_pkg::csr_addr_t               avl_mm_address;
	eth_tc_pkg::csr_data_t               avl_mm_writedata;
	wire eth_tc_pkg::csr_data_t          avl_mm_readdata;
	wire                                 avl_mm_readdatavalid;
	wire eth_tc_pkg::st_beat_t [NCH-1:0] tx_beat;
	wire [NCH-1:0]                       tx_valid;
	logic [NCH-1:0]                      tx_ready;
	eth_tc_pkg::st_beat_t [NCH-1:0]      rx_beat;
	logic [NCH-1:0]                      rx_valid;
	wire [NCH-1:0]                       rx_ready;
	logic [NCH-1:0]                      stop_mon;
	wire [NCH-1:0]                       mon_active;
	wire [NCH-1:0]                       mon_done;
	wire [NCH-1:0]                       mon_error;

	integer     seed = 43;
	int         errors = 0;
	logic [NCH-1:0] bp = '0;
	logic       inj_en = 1'b0;
	int         inj_ch = 0;
	int         inj_pkt = 0;
	int         inj_beat = 0;
	int         sb_pkt [NCH];
	int         sb_beat [NCH];
	int         sb_len [NCH];

	eth_traffic_controller_top #(
		.NUM_CHANNELS (NCH)
	) i_dut (
		.clk                  (clk),
		.rst_n                (rst_n),
		.avl_mm_read          (avl_mm_read),
		.avl_mm_write         (avl_mm_write),
		.avl_mm_address       (avl_mm_address),
		.avl_mm_writedata     (avl_mm_writedata),
		.avl_mm_readdata      (avl_mm_readdata),
		.avl_mm_readdatavalid (avl_mm_readdatavalid),
		.tx_beat              (tx_beat),
		.tx_valid             (tx_valid),
		.tx_ready             (tx_ready),
		.rx_beat              (rx_beat),
		.rx_valid             (rx_valid),
		.rx_ready             (rx_ready),
		.stop_mon             (stop_mon),
		.mon_active           (mon_active),
		.mon_done             (mon_done),
		.mon_error            (mon_error)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// loopback with fault injection
	//////////////////////////////
	always @(negedge clk)
	begin
		for (int c = 0; c < NCH; c++)
			bp[c] = (($random(seed) & 3) != 0);
	end

	// a transfer happens on both sides in the same cycle
	always_comb
	begin
		for (int c = 0; c < NCH; c++)
		begin
			rx_beat[c]  = tx_beat[c];
			rx_valid[c] = tx_valid[c] && bp[c];
			tx_ready[c] = rx_ready[c] && bp[c];
			if (inj_en && c == inj_ch && tx_beat[c].data[63:32] == 32'(inj_pkt)
				&& tx_beat[c].data[31:0] == 32'(inj_beat))
				rx_beat[c].data[40] = ~tx_beat[c].data[40];
		end
	end

	// beat k of packet p where length 0 behaves as 1 byte
	function automatic eth_tc_pkg::st_beat_t expected_beat(input int pkt, input int k,
		input int len);
		eth_tc_pkg::st_beat_t b;
		int                   l;
		int                   nb;
		l       = (len == 0) ? 1 : len;
		nb      = (l + 7) / 8;
		b.data  = {32'(pkt), 32'(k)};
		b.sop   = (k == 0);
		b.eop   = (k == nb - 1);
		b.empty = b.eop ? 3'(8 * nb - l) : 3'd0;
		b.error = 1'b0;
		return b;
	endfunction

	task automatic report_mismatch(input string name, input logic [69:0] exp,
		input logic [69:0] act);
		errors++;
		$display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
	endtask

	// tx port scoreboard
	always @(posedge clk)
	begin : scoreboard
		eth_tc_pkg::st_beat_t exp_b;
		for (int c = 0; c < NCH; c++)
		begin
			if (rst_n && tx_valid[c] && tx_ready[c])
			begin
				exp_b = expected_beat(sb_pkt[c], sb_beat[c], sb_len[c]);
				assert (tx_beat[c] == exp_b)
				else
					report_mismatch($sformatf("tx_beat[%0d]", c), exp_b, tx_beat[c]);
				if (exp_b.eop)
				begin
					sb_pkt[c]++;
					sb_beat[c] = 0;
				end
				else
					sb_beat[c]++;
			end
		end
	end

	//////////////////////////////
	// register access
	//////////////////////////////
	task automatic write_reg(input int region, input eth_tc_pkg::reg_off_t off,
		input eth_tc_pkg::csr_data_t data);
		@(negedge clk);
		avl_mm_write     = 1'b1;
		avl_mm_address   = {eth_tc_pkg::region_t'(region), off};
		avl_mm_writedata = data;
		@(negedge clk);
		avl_mm_write     = 1'b0;
	endtask

	task automatic read_reg(input int region, input eth_tc_pkg::reg_off_t off,
		output eth_tc_pkg::csr_data_t data);
		int t;
		@(negedge clk);
		avl_mm_read    = 1'b1;
		avl_mm_address = {eth_tc_pkg::region_t'(region), off};
		@(negedge clk);
		avl_mm_read    = 1'b0;
		t = 0;
		while (!avl_mm_readdatavalid && t < 10)
		begin
			@(negedge clk);
			t++;
		end
		data = avl_mm_readdatavalid ? avl_mm_readdata : 'x;
		if (!avl_mm_readdatavalid)
		begin
			errors++;
			$display("no readdatavalid for read of region %0d offset %0d", region, off);
		end
	endtask

	task automatic check_reg(input int region, input eth_tc_pkg::reg_off_t off,
		input eth_tc_pkg::csr_data_t exp);
		eth_tc_pkg::csr_data_t v;
		read_reg(region, off, v);
		assert (v == exp)
		else
			report_mismatch($sformatf("avl_mm_readdata region %0d offset %0d", region, off),
				exp, v);
	endtask

	task automatic check_bit(input logic act, input logic exp, input string name);
		assert (act == exp)
		else
			report_mismatch(name, exp, act);
	endtask

	task automatic start_run(input int ch, input int count, input int len);
		write_reg(ch, eth_tc_pkg::REG_PKT_COUNT, count);
		write_reg(ch, eth_tc_pkg::REG_PKT_LEN, len);
		sb_pkt[ch]  = 0;
		sb_beat[ch] = 0;
		sb_len[ch]  = len;
		write_reg(ch, eth_tc_pkg::REG_CTRL, 32'h1);
		// first beat is up one cycle after the start write
		check_bit(tx_valid[ch], 1'b1, $sformatf("tx_valid[%0d]", ch));
	endtask

	task automatic wait_done(input int ch);
		int t;
		t = 0;
		while (!mon_done[ch] && t < 5000)
		begin
			@(negedge clk);
			t++;
		end
		if (!mon_done[ch])
		begin
			errors++;
			$display("timeout waiting for mon_done on channel %0d", ch);
		end
	endtask

	task automatic wait_sent(input int ch, input int n);
		int t;
		t = 0;
		while (sb_pkt[ch] < n && t < 5000)
		begin
			@(negedge clk);
			t++;
		end
		if (sb_pkt[ch] < n)
		begin
			errors++;
			$display("timeout waiting for %0d packets on channel %0d", n, ch);
		end
	endtask

	task automatic wait_tx_idle(input int ch);
		int t;
		t = 0;
		while (tx_valid[ch] && t < 5000)
		begin
			@(negedge clk);
			t++;
		end
		if (tx_valid[ch])
		begin
			errors++;
			$display("timeout waiting for the generator of channel %0d to finish", ch);
		end
	endtask

	task automatic check_cleared(input int ch);
		write_reg(ch, eth_tc_pkg::REG_CTRL, 32'h2);
		check_reg(ch, eth_tc_pkg::REG_TX_SENT, 0);
		check_reg(ch, eth_tc_pkg::REG_RX_GOOD, 0);
		check_reg(ch, eth_tc_pkg::REG_RX_BAD, 0);
		check_bit(mon_error[ch], 1'b0, $sformatf("mon_error[%0d]", ch));
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial
	begin
		rst_n            = 1'b1;
		avl_mm_read      = 1'b0;
		avl_mm_write     = 1'b0;
		avl_mm_address   = '0;
		avl_mm_writedata = '0;
		stop_mon         = '0;
		for (int c = 0; c < NCH; c++)
		begin
			sb_pkt[c]  = 0;
			sb_beat[c] = 0;
			sb_len[c]  = 0;
		end
		#10 rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// register readback and unmapped regions
		write_reg(0, eth_tc_pkg::REG_PKT_COUNT, 5);
		write_reg(0, eth_tc_pkg::REG_PKT_LEN, 20);
		write_reg(1, eth_tc_pkg::REG_PKT_COUNT, 3);
		write_reg(1, eth_tc_pkg::REG_PKT_LEN, 9);
		check_reg(0, eth_tc_pkg::REG_PKT_COUNT, 5);
		check_reg(0, eth_tc_pkg::REG_PKT_LEN, 20);
		check_reg(1, eth_tc_pkg::REG_PKT_COUNT, 3);
		check_reg(1, eth_tc_pkg::REG_PKT_LEN, 9);
		check_reg(2, eth_tc_pkg::REG_PKT_COUNT, 0);
		check_reg(3, eth_tc_pkg::REG_PKT_LEN, 0);

		// clean run under back-pressure
		start_run(0, 5, 20);
		wait_done(0);
		check_reg(0, eth_tc_pkg::REG_TX_SENT, 5);
		check_reg(0, eth_tc_pkg::REG_RX_GOOD, 5);
		check_reg(0, eth_tc_pkg::REG_RX_BAD, 0);
		check_bit(mon_done[0], 1'b1, "mon_done[0]");
		check_bit(mon_error[0], 1'b0, "mon_error[0]");
		check_bit(tx_valid[0], 1'b0, "tx_valid[0]");

		// short lengths with empty checked by the scoreboard
		for (int i = 0; i < 4; i++)
		begin
			start_run(1, 2, RUN_LENS[i]);
			wait_done(1);
			check_reg(1, eth_tc_pkg::REG_RX_GOOD, 2);
		end

		// one flipped bit on channel 0 while channel 1 runs clean
		inj_ch   = 0;
		inj_pkt  = 2;
		inj_beat = 1;
		inj_en   = 1'b1;
		start_run(0, 4, 24);
		start_run(1, 4, 24);
		wait_done(0);
		wait_done(1);
		inj_en = 1'b0;
		check_reg(0, eth_tc_pkg::REG_RX_BAD, 1);
		check_reg(0, eth_tc_pkg::REG_RX_GOOD, 3);
		check_bit(mon_error[0], 1'b1, "mon_error[0]");
		check_reg(1, eth_tc_pkg::REG_RX_BAD, 0);
		check_reg(1, eth_tc_pkg::REG_RX_GOOD, 4);
		check_bit(mon_error[1], 1'b0, "mon_error[1]");
		check_cleared(0);

		// stop in the middle of a run
		start_run(0, 20, 64);
		wait_sent(0, 2);
		check_bit(mon_active[0], 1'b1, "mon_active[0]");
		@(negedge clk);
		stop_mon[0] = 1'b1;
		@(negedge clk);
		check_bit(rx_ready[0], 1'b0, "rx_ready[0]");
		check_bit(mon_active[0], 1'b0, "mon_active[0]");
		stop_mon[0] = 1'b0;
		wait_tx_idle(0);
		check_cleared(0);

		repeat (4) @(negedge clk);
		$display("check errors: %0d, assertion failures: %0d", errors,
			i_dut.i_asserts.fail_count);
		if (errors == 0 && i_dut.i_asserts.fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== eth_tc_asserts.sv ====
/*
 * ethernet traffic controller port assertions
 * read latency, transmit hold under back-pressure and quiet reset,
 * bound onto the top level
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tc_asserts #(
	parameter int NUM_CHANNELS = 2
) (
	input wire                                          clk,
	input wire                                          rst_n,
	input wire                                          avl_mm_read,
	input wire                                          avl_mm_readdatavalid,
	input wire eth_tc_pkg::st_beat_t [NUM_CHANNELS-1:0] tx_beat,
	input wire [NUM_CHANNELS-1:0]                       tx_valid,
	input wire [NUM_CHANNELS-1:0]                       tx_ready,
	input wire [NUM_CHANNELS-1:0]                       mon_active,
	input wire [NUM_CHANNELS-1:0]                       mon_done,
	input wire [NUM_CHANNELS-1:0]                       mon_error
);

	int fail_count = 0;

	//////////////////////////////
	// register port
	//////////////////////////////
	a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
		avl_mm_read |=> avl_mm_readdatavalid)
	else
	begin
		fail_count++;
		$error("readdatavalid missing one cycle after a read");
	end

	// every response must belong to a read
	a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
		avl_mm_readdatavalid |-> $past(avl_mm_read))
	else
	begin
		fail_count++;
		$error("readdatavalid without a read in the previous cycle");
	end

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !avl_mm_readdatavalid && (tx_valid == '0) && (mon_active == '0)
			&& (mon_done == '0) && (mon_error == '0))
	else
	begin
		fail_count++;
		$error("control output high during reset");
	end

	//////////////////////////////
	// transmit streams
	//////////////////////////////
	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_tx
		a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
			tx_valid[i] && !tx_ready[i] |=> tx_valid[i] && $stable(tx_beat[i]))
		else
		begin
			fail_count++;
			$error("tx beat of channel %0d changed under back-pressure", i);
		end
	end

endmodule

bind eth_traffic_controller_top eth_tc_asserts #(
	.NUM_CHANNELS (NUM_CHANNELS)
) i_asserts (
	.clk                  (clk),
	.rst_n                (rst_n),
	.avl_mm_read          (avl_mm_read),
	.avl_mm_readdatavalid (avl_mm_readdatavalid),
	.tx_beat              (tx_beat),
	.tx_valid             (tx_valid),
	.tx_ready             (tx_ready),
	.mon_active           (mon_active),
	.mon_done             (mon_done),
	.mon_error            (mon_error)
);

`default_nettype wire

// ==== eth_traffic_controller_top.sv ====
/*
 * ethernet traffic controller
 * one register port decoded into NUM_CHANNELS standard channels,
 * each with its own transmit and receive stream and monitor controls
 */
`timescale 1ns/1ps
`default_nettype none

module eth_traffic_controller_top #(
	parameter int NUM_CHANNELS = 2
) (
	input  wire                                          clk,
	input  wire                                          rst_n,

	// register port
	input  wire                                          avl_mm_read,
	input  wire                                          avl_mm_write,
	input  wire eth_tc_pkg::csr_addr_t                   avl_mm_address,
	input  wire eth_tc_pkg::csr_data_t                   avl_mm_writedata,
	output wire eth_tc_pkg::csr_data_t                   avl_mm_readdata,
	output wire                                          avl_mm_readdatavalid,

	// streams
	output wire eth_tc_pkg::st_beat_t [NUM_CHANNELS-1:0] tx_beat,
	output wire [NUM_CHANNELS-1:0]                       tx_valid,
	input  wire [NUM_CHANNELS-1:0]                       tx_ready,
	input  wire eth_tc_pkg::st_beat_t [NUM_CHANNELS-1:0] rx_beat,
	input  wire [NUM_CHANNELS-1:0]                       rx_valid,
	output wire [NUM_CHANNELS-1:0]                       rx_ready,

	// monitor control
	input  wire [NUM_CHANNELS-1:0]                       stop_mon,
	output wire [NUM_CHANNELS-1:0]                       mon_active,
	output wire [NUM_CHANNELS-1:0]                       mon_done,
	output wire [NUM_CHANNELS-1:0]                       mon_error
);

	wire eth_tc_pkg::csr_req_t [NUM_CHANNELS-1:0] csr_req;
	wire eth_tc_pkg::csr_rsp_t [NUM_CHANNELS-1:0] csr_rsp;
	wire                                          miss_rvalid;

	eth_tc_csr_decode #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) decode_u0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.avl_mm_read      (avl_mm_read),
		.avl_mm_write     (avl_mm_write),
		.avl_mm_address   (avl_mm_address),
		.avl_mm_writedata (avl_mm_writedata),
		.csr_req          (csr_req),
		.miss_rvalid      (miss_rvalid)
	);

	// region i of the address map is channel i
	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_channel
		eth_std_channel channel_u0 (
			.clk        (clk),
			.rst_n      (rst_n),
			.csr_req    (csr_req[i]),
			.tx_ready   (tx_ready[i]),
			.rx_beat    (rx_beat[i]),
			.rx_valid   (rx_valid[i]),
			.stop_mon   (stop_mon[i]),
			.csr_rsp    (csr_rsp[i]),
			.tx_beat    (tx_beat[i]),
			.tx_valid   (tx_valid[i]),
			.rx_ready   (rx_ready[i]),
			.mon_active (mon_active[i]),
			.mon_done   (mon_done[i]),
			.mon_error  (mon_error[i])
		);
	end

	eth_tc_readback #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) readback_u0 (
		.csr_rsp              (csr_rsp),
		.miss_rvalid          (miss_rvalid),
		.avl_mm_readdata      (avl_mm_readdata),
		.avl_mm_readdatavalid (avl_mm_readdatavalid)
	);

endmodule

`default_nettype wire

// ==== eth_tc_readback.sv ====
/*
 * register readback merge
 * picks the one valid channel response, a miss reads as zero
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tc_readback #(
	parameter int NUM_CHANNELS = 2
) (
	input  wire eth_tc_pkg::csr_rsp_t [NUM_CHANNELS-1:0] csr_rsp,
	input  wire                                          miss_rvalid,
	output eth_tc_pkg::csr_data_t                        avl_mm_readdata,
	output logic                                         avl_mm_readdatavalid
);

	// responses are already registered, merge stays combinational
	always_comb
	begin
		avl_mm_readdata      = '0;
		avl_mm_readdatavalid = miss_rvalid;
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			// at most one request per cycle, so at most one hit
			if (csr_rsp[i].rvalid)
			begin
				avl_mm_readdata      = csr_rsp[i].rdata;
				avl_mm_readdatavalid = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== eth_std_channel.sv ====
/*
 * standard traffic channel
 * register block with packet count and length, start and clear pulses,
 * and the packet generator and monitor that share these settings
 */
`timescale 1ns/1ps
`default_nettype none

module eth_std_channel (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire eth_tc_pkg::csr_req_t  csr_req,
	input  wire                        tx_ready,
	input  wire eth_tc_pkg::st_beat_t  rx_beat,
	input  wire                        rx_valid,
	input  wire                        stop_mon,
	output eth_tc_pkg::csr_rsp_t       csr_rsp,
	output eth_tc_pkg::st_beat_t       tx_beat,
	output logic                       tx_valid,
	output logic                       rx_ready,
	output logic                       mon_active,
	output logic                       mon_done,
	output logic                       mon_error
);

	eth_tc_pkg::pkt_cnt_t  pkt_count;
	eth_tc_pkg::pkt_len_t  pkt_len;
	eth_tc_pkg::pkt_cnt_t  tx_sent;
	eth_tc_pkg::pkt_cnt_t  rx_good;
	eth_tc_pkg::pkt_cnt_t  rx_bad;
	eth_tc_pkg::csr_data_t rd_mux;
	eth_tc_pkg::csr_data_t rsp_data;
	logic                  rsp_valid;
	logic                  ctrl_wr;
	logic                  start;
	logic                  clear;

	assign ctrl_wr = csr_req.wr && (csr_req.off == eth_tc_pkg::REG_CTRL);
	assign start   = ctrl_wr && csr_req.wdata[0];
	assign clear   = ctrl_wr && csr_req.wdata[1];

	//////////////////////////////
	// configuration registers
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pkt_count <= '0;
			pkt_len   <= '0;
		end
		else if (csr_req.wr)
		begin
			case (csr_req.off)
				eth_tc_pkg::REG_PKT_COUNT: pkt_count <= csr_req.wdata;
				eth_tc_pkg::REG_PKT_LEN:   pkt_len <= eth_tc_pkg::pkt_len_t'(csr_req.wdata);
				default: ;
			endcase
		end
	end

	// ctrl reads back 0, the pulses do not stick
	always_comb
	begin
		case (csr_req.off)
			eth_tc_pkg::REG_PKT_COUNT: rd_mux = pkt_count;
			eth_tc_pkg::REG_PKT_LEN:   rd_mux = {16'd0, pkt_len};
			eth_tc_pkg::REG_TX_SENT:   rd_mux = tx_sent;
			eth_tc_pkg::REG_RX_GOOD:   rd_mux = rx_good;
			eth_tc_pkg::REG_RX_BAD:    rd_mux = rx_bad;
			default:                   rd_mux = '0;
		endcase
	end

	// one cycle read response
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= csr_req.rd;
	end

	always_ff @(posedge clk)
	begin
		if (csr_req.rd)
			rsp_data <= rd_mux;
	end

	assign csr_rsp = '{rvalid: rsp_valid, rdata: rsp_data};

	eth_pkt_gen gen_u0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.clear     (clear),
		.pkt_count (pkt_count),
		.pkt_len   (pkt_len),
		.tx_ready  (tx_ready),
		.tx_beat   (tx_beat),
		.tx_valid  (tx_valid),
		.tx_sent   (tx_sent)
	);

	eth_pkt_mon mon_u0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.clear      (clear),
		.stop_mon   (stop_mon),
		.pkt_count  (pkt_count),
		.pkt_len    (pkt_len),
		.rx_beat    (rx_beat),
		.rx_valid   (rx_valid),
		.rx_ready   (rx_ready),
		.rx_good    (rx_good),
		.rx_bad     (rx_bad),
		.mon_active (mon_active),
		.mon_done   (mon_done),
		.mon_error  (mon_error)
	);

endmodule

`default_nettype wire

// ==== eth_pkt_mon.sv ====
/*
 * packet monitor
 * checks received beats against the generator pattern,
 * counts good and bad packets and reports active, done and error
 */
`timescale 1ns/1ps
`default_nettype none

module eth_pkt_mon (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire                        clear,
	input  wire                        stop_mon,
	input  wire eth_tc_pkg::pkt_cnt_t  pkt_count,
	input  wire eth_tc_pkg::pkt_len_t  pkt_len,
	input  wire eth_tc_pkg::st_beat_t  rx_beat,
	input  wire                        rx_valid,
	output logic                       rx_ready,
	output eth_tc_pkg::pkt_cnt_t       rx_good,
	output eth_tc_pkg::pkt_cnt_t       rx_bad,
	output logic                       mon_active,
	output logic                       mon_done,
	output logic                       mon_error
);

	eth_tc_pkg::pkt_cnt_t run_count;
	eth_tc_pkg::pkt_cnt_t seen;
	eth_tc_pkg::pkt_len_t run_len;
	eth_tc_pkg::pkt_len_t exp_idx;
	eth_tc_pkg::st_beat_t exp_beat;
	logic                 accept;
	logic                 beat_fault;
	logic                 pkt_fault;
	logic                 pkt_bad;

	assign rx_ready = !stop_mon;
	// beats outside a run are drained but not checked
	assign accept   = rx_valid && rx_ready && mon_active;

	// good or bad, every packet moves the expected number on
	assign seen     = rx_good + rx_bad;
	assign exp_beat = eth_tc_pkg::pattern_beat(seen, exp_idx, run_len);

	// covers data, sop, eop, empty and error in one compare
	assign beat_fault = (rx_beat != exp_beat);
	assign pkt_bad    = pkt_fault || beat_fault;
	assign mon_error  = (rx_bad != '0);

	//////////////////////////////
	// checker and counters
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_count  <= '0;
			run_len    <= '0;
			exp_idx    <= '0;
			pkt_fault  <= 1'b0;
			rx_good    <= '0;
			rx_bad     <= '0;
			mon_active <= 1'b0;
			mon_done   <= 1'b0;
		end
		else if (start || clear)
		begin
			run_count  <= pkt_count;
			run_len    <= pkt_len;
			exp_idx    <= '0;
			pkt_fault  <= 1'b0;
			rx_good    <= '0;
			rx_bad     <= '0;
			mon_active <= start && (pkt_count != '0);
			mon_done   <= start && (pkt_count == '0);
		end
		else
		begin
			if (stop_mon)
				mon_active <= 1'b0;
			if (accept && rx_beat.eop)
			begin
				// packet ends on the received eop, early or late
				exp_idx   <= '0;
				pkt_fault <= 1'b0;
				if (pkt_bad)
					rx_bad <= rx_bad + 1'b1;
				else
					rx_good <= rx_good + 1'b1;
				if (seen + 1'b1 == run_count)
				begin
					mon_done   <= 1'b1;
					mon_active <= 1'b0;
				end
			end
			else if (accept)
			begin
				exp_idx   <= exp_idx + 1'b1;
				pkt_fault <= pkt_bad;
			end
		end
	end

endmodule

`default_nettype wire

// ==== eth_pkt_gen.sv ====
/*
 * packet generator
 * sends the programmed number of pattern packets on the transmit stream,
 * holding each beat under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module eth_pkt_gen (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire                        clear,
	input  wire eth_tc_pkg::pkt_cnt_t  pkt_count,
	input  wire eth_tc_pkg::pkt_len_t  pkt_len,
	input  wire                        tx_ready,
	output eth_tc_pkg::st_beat_t       tx_beat,
	output logic                       tx_valid,
	output eth_tc_pkg::pkt_cnt_t       tx_sent
);

	eth_tc_pkg::gen_state_t state;
	eth_tc_pkg::pkt_cnt_t   pkt_idx;
	eth_tc_pkg::pkt_cnt_t   run_count;
	eth_tc_pkg::pkt_len_t   run_len;
	eth_tc_pkg::pkt_len_t   beat_idx;
	logic                   xfer;

	// beat is a pure function of the counters, so it holds until it moves
	assign tx_beat  = eth_tc_pkg::pattern_beat(pkt_idx, beat_idx, run_len);
	assign tx_valid = (state == eth_tc_pkg::GEN_SEND);
	assign xfer     = tx_valid && tx_ready;

	// packet index doubles as the sent counter
	assign tx_sent = pkt_idx;

	//////////////////////////////
	// generator FSM
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= eth_tc_pkg::GEN_IDLE;
			pkt_idx   <= '0;
			beat_idx  <= '0;
			run_count <= '0;
			run_len   <= '0;
		end
		else if (start || clear)
		begin
			pkt_idx   <= '0;
			beat_idx  <= '0;
			// settings are frozen for the whole run
			run_count <= pkt_count;
			run_len   <= pkt_len;
			if (!start)
				state <= eth_tc_pkg::GEN_IDLE;
			else if (pkt_count == '0)
				state <= eth_tc_pkg::GEN_DONE;
			else
				state <= eth_tc_pkg::GEN_SEND;
		end
		else
		begin
			case (state)
				eth_tc_pkg::GEN_SEND:
				begin
					if (xfer && tx_beat.eop)
					begin
						beat_idx <= '0;
						pkt_idx  <= pkt_idx + 1'b1;
						if (pkt_idx + 1'b1 == run_count)
							state <= eth_tc_pkg::GEN_DONE;
					end
					else if (xfer)
					begin
						beat_idx <= beat_idx + 1'b1;
					end
				end
				// idle and done wait for the next start or clear
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== eth_tc_csr_decode.sv ====
/*
 * register port decoder
 * splits the word address into a channel region and a register offset,
 * steers read and write to the matching channel and flags reads that miss
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tc_csr_decode #(
	parameter int NUM_CHANNELS = 2
) (
	input  wire                                       clk,
	input  wire                                       rst_n,
	input  wire                                       avl_mm_read,
	input  wire                                       avl_mm_write,
	input  wire eth_tc_pkg::csr_addr_t                avl_mm_address,
	input  wire eth_tc_pkg::csr_data_t                avl_mm_writedata,
	output eth_tc_pkg::csr_req_t [NUM_CHANNELS-1:0]   csr_req,
	output logic                                      miss_rvalid
);

	eth_tc_pkg::region_t  region;
	eth_tc_pkg::reg_off_t offset;
	logic                 hit;

	assign {region, offset} = avl_mm_address;
	assign hit = (int'(region) < NUM_CHANNELS);

	// offset and data go to all channels, strobes only to the selected one
	always_comb
	begin
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			csr_req[i].rd    = avl_mm_read && (int'(region) == i);
			csr_req[i].wr    = avl_mm_write && (int'(region) == i);
			csr_req[i].off   = offset;
			csr_req[i].wdata = avl_mm_writedata;
		end
	end

	// read to an empty region, answered a cycle later like a channel
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			miss_rvalid <= 1'b0;
		else
			miss_rvalid <= avl_mm_read && !hit;
	end

endmodule

`default_nettype wire

// ==== eth_tc_pkg.sv ====
/*
 * ethernet traffic controller shared definitions
 * widths, register map, register port and stream structs,
 * and the test pattern used by the generator and the monitor
 */
`default_nettype none

package eth_tc_pkg;

	typedef logic [63:0] beat_t;
	typedef logic [2:0]  empty_t;
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [11:0] reg_off_t;
	typedef logic [1:0]  region_t;
	typedef logic [15:0] pkt_len_t;
	typedef logic [31:0] pkt_cnt_t;

	localparam int BEAT_BYTES = 8;

	//////////////////////////////
	// register map, per channel
	//////////////////////////////
	// ctrl bit 0 start, bit 1 clear, both write-one pulses
	localparam reg_off_t REG_CTRL      = 12'd0;
	localparam reg_off_t REG_PKT_COUNT = 12'd1;
	localparam reg_off_t REG_PKT_LEN   = 12'd2;
	localparam reg_off_t REG_TX_SENT   = 12'd3;
	localparam reg_off_t REG_RX_GOOD   = 12'd4;
	localparam reg_off_t REG_RX_BAD    = 12'd5;

	typedef struct packed {
		logic      rd;
		logic      wr;
		reg_off_t  off;
		csr_data_t wdata;
	} csr_req_t;

	typedef struct packed {
		logic      rvalid;
		csr_data_t rdata;
	} csr_rsp_t;

	typedef struct packed {
		beat_t  data;
		logic   sop;
		logic   eop;
		empty_t empty;
		logic   error;
	} st_beat_t;

	typedef enum logic [1:0] {
		GEN_IDLE,
		GEN_SEND,
		GEN_DONE
	} gen_state_t;

	// beat idx of packet pkt for a packet of len bytes, zero length counts as one byte
	function automatic st_beat_t pattern_beat(input pkt_cnt_t pkt, input pkt_len_t idx,
		input pkt_len_t len);
		st_beat_t    b;
		logic [16:0] eff;
		logic [16:0] beats;
		eff     = (len == '0) ? 17'd1 : {1'b0, len};
		beats   = (eff + 17'(BEAT_BYTES - 1)) / 17'(BEAT_BYTES);
		b.data  = {pkt, 16'd0, idx};
		b.sop   = (idx == '0);
		b.eop   = ({1'b0, idx} == beats - 17'd1);
		b.empty = b.eop ? empty_t'(beats * 17'(BEAT_BYTES) - eff) : '0;
		b.error = 1'b0;
		return b;
	endfunction

endpackage

`default_nettype wire
